/* hdl/mod503_pkg.sv */
package mod503_pkg;

  // Modulus and widths.
  parameter int MODULUS        = 503;
  parameter int RES_W          = 9;
  parameter int OPERAND_W      = 100;
  parameter int CHUNK_W        = 6;
  parameter int NUM_MID_CHUNKS = 15;
  parameter int TOP_W          = 4;

  // --------------------
  // Operand word
  // --------------------

  typedef struct packed {
    logic [TOP_W-1:0]                         top;  // Chunk position 16, partial.
    logic [NUM_MID_CHUNKS-1:0][CHUNK_W-1:0]   mid;  // Entry k is position k+1.
    logic [CHUNK_W-1:0]                       low;  // Weight 1, added as is.
  } operand_chunks_t;

  // Written flat by the collector, read as chunks by the reducer.
  typedef union packed {
    logic [OPERAND_W-1:0] flat;
    operand_chunks_t      chunks;
  } operand_u;

endpackage

/* hdl/chunk_residue.sv */
`timescale 1ns/1ps

module chunk_residue #(
  parameter int POSITION = 1
) (
  input  logic [mod503_pkg::CHUNK_W-1:0] chunk,
  output logic [mod503_pkg::RES_W-1:0]   residue
);

  // 2^(6*pos) mod 503, by repeated doubling.
  function automatic int pos_weight(input int pos);
    int w;
    w = 1;
    for (int i = 0; i < pos * mod503_pkg::CHUNK_W; i++)
      w = (w * 2) % mod503_pkg::MODULUS;
    return w;
  endfunction

  localparam int WEIGHT = pos_weight(POSITION);
  localparam int FOLD   = (1 << mod503_pkg::RES_W) % mod503_pkg::MODULUS;  // 512 mod 503.
  localparam int PROD_W = mod503_pkg::CHUNK_W + mod503_pkg::RES_W;

  logic [PROD_W-1:0] prod;
  logic [10:0]       fold_1;   // At most 1060.
  logic [9:0]        fold_2;   // At most 520.
  logic [9:0]        corrected;

  assign prod   = PROD_W'(chunk) * PROD_W'(WEIGHT);
  assign fold_1 = 11'(prod[8:0]) + 11'(prod[PROD_W-1:9]) * 11'(FOLD);
  assign fold_2 = 10'(fold_1[8:0]) + 10'(fold_1[10:9]) * 10'(FOLD);

  assign corrected = (fold_2 >= 10'(mod503_pkg::MODULUS)) ?
                     fold_2 - 10'(mod503_pkg::MODULUS) : fold_2;
  assign residue   = corrected[mod503_pkg::RES_W-1:0];

endmodule

/* hdl/mod_reduce_100.sv */
`timescale 1ns/1ps

module mod_reduce_100 (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         go,
  input  mod503_pkg::operand_u         operand,
  output logic                         result_valid,
  output logic [mod503_pkg::RES_W-1:0] residue
);

  localparam int NUM_CHUNKS = mod503_pkg::NUM_MID_CHUNKS + 1;
  localparam int HALF       = NUM_CHUNKS / 2;
  localparam int SUM_W      = 12;  // Eight residues, at most 4016.
  localparam int F1_W       = 11;
  localparam int F2_W       = 10;
  localparam int W64        = (1 << mod503_pkg::CHUNK_W) % mod503_pkg::MODULUS;
  localparam int W512       = (1 << mod503_pkg::RES_W) % mod503_pkg::MODULUS;

  logic [mod503_pkg::RES_W-1:0]   chunk_res [NUM_CHUNKS];
  logic [SUM_W-1:0]               sum_a;
  logic [SUM_W-1:0]               sum_b;
  logic [SUM_W-1:0]               s1_sum_a;
  logic [SUM_W-1:0]               s1_sum_b;
  logic [mod503_pkg::CHUNK_W-1:0] s1_low;
  logic                           s1_valid;
  logic [F1_W-1:0]                fold_1;
  logic [F2_W-1:0]                fold_2;
  logic [F2_W-1:0]                corrected;

  // --------------------
  // Chunk residues
  // --------------------

  genvar k;
  for (k = 1; k <= NUM_CHUNKS; k++)
  begin : g_chunk
    logic [mod503_pkg::CHUNK_W-1:0] chunk_in;

    if (k <= mod503_pkg::NUM_MID_CHUNKS)
    begin : g_mid
      assign chunk_in = operand.chunks.mid[k-1];
    end
    else
    begin : g_top
      assign chunk_in = {{(mod503_pkg::CHUNK_W - mod503_pkg::TOP_W){1'b0}},
                         operand.chunks.top};
    end

    chunk_residue #(
      .POSITION (k)
    ) u_chunk (
      .chunk   (chunk_in),
      .residue (chunk_res[k-1])
    );
  end

  always_comb
  begin
    sum_a = '0;
    sum_b = '0;
    for (int i = 0; i < HALF; i++)
    begin
      sum_a = sum_a + SUM_W'(chunk_res[i]);
      sum_b = sum_b + SUM_W'(chunk_res[i + HALF]);
    end
  end

  // --------------------
  // Stage one
  // --------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_sum_a <= '0;
      s1_sum_b <= '0;
      s1_low   <= '0;
      s1_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= go;
      if (go)
      begin
        s1_sum_a <= sum_a;
        s1_sum_b <= sum_b;
        s1_low   <= operand.chunks.low;
      end
    end
  end

  // --------------------
  // Stage two
  // --------------------

  // Bits 6..8 weigh 64, bits 9 and up weigh 9.
  assign fold_1 = F1_W'(s1_sum_a[5:0]) + F1_W'(s1_sum_a[8:6]) * F1_W'(W64) +
                  F1_W'(s1_sum_a[11:9]) * F1_W'(W512) +
                  F1_W'(s1_sum_b[5:0]) + F1_W'(s1_sum_b[8:6]) * F1_W'(W64) +
                  F1_W'(s1_sum_b[11:9]) * F1_W'(W512);

  assign fold_2 = F2_W'(fold_1[5:0]) + F2_W'(fold_1[8:6]) * F2_W'(W64) +
                  F2_W'(fold_1[10:9]) * F2_W'(W512) + F2_W'(s1_low);

  assign corrected = (fold_2 >= F2_W'(mod503_pkg::MODULUS)) ?
                     fold_2 - F2_W'(mod503_pkg::MODULUS) : fold_2;  // Below 1006.

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      result_valid <= 1'b0;
      residue      <= '0;
    end
    else
    begin
      result_valid <= s1_valid;
      if (s1_valid)
        residue <= corrected[mod503_pkg::RES_W-1:0];  // Held until next result.
    end
  end

endmodule

/* hdl/operand_shifter.sv */
`timescale 1ns/1ps

module operand_shifter #(
  parameter int WORD_W = 20
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 shift_en,
  input  logic [WORD_W-1:0]    word,
  output mod503_pkg::operand_u operand
);

  localparam int KEEP_W = mod503_pkg::OPERAND_W - WORD_W;

  // First word ends up in the top bits.
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      operand.flat <= '0;
    else if (shift_en)
      operand.flat <= {operand.flat[KEEP_W-1:0], word};
  end

endmodule

/* hdl/word_counter.sv */
`timescale 1ns/1ps

module word_counter #(
  parameter int NUM_WORDS = 5
) (
  input  logic clk,
  input  logic arst_n,
  input  logic shift_en,
  output logic last_word
);

  localparam int CNT_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  logic [CNT_W-1:0] count;

  assign last_word = shift_en && (count == CNT_W'(NUM_WORDS - 1));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      count <= '0;
    else if (shift_en)
    begin
      if (last_word)
        count <= '0;  // Wrap for next operand.
      else
        count <= count + 1'b1;
    end
  end

endmodule

/* hdl/reduce_ctrl.sv */
`timescale 1ns/1ps

module reduce_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic word_valid,
  input  logic last_word,
  input  logic result_valid,
  output logic shift_en,
  output logic go,
  output logic busy
);

  localparam logic [1:0] LOAD   = 2'd0;
  localparam logic [1:0] REDUCE = 2'd1;
  localparam logic [1:0] WAIT   = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;

  assign shift_en = word_valid && !busy;  // Dropped while busy.
  assign go       = (state == REDUCE);

  always_comb
  begin
    state_next = state;
    case (state)
      LOAD:
        if (last_word)
          state_next = REDUCE;
      REDUCE:
        state_next = WAIT;
      WAIT:
        if (result_valid)
          state_next = LOAD;
      default:
        state_next = LOAD;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= LOAD;
      busy  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      busy  <= (state_next != LOAD);
    end
  end

endmodule

/* hdl/mod503_top.sv */
`timescale 1ns/1ps

module mod503_top #(
  parameter int WORD_W = 20
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         word_valid,
  input  logic [WORD_W-1:0]            word,
  output logic                         busy,
  output logic                         result_valid,
  output logic [mod503_pkg::RES_W-1:0] residue
);

  localparam int NUM_WORDS = mod503_pkg::OPERAND_W / WORD_W;

  logic                 shift_en;
  logic                 last_word;
  logic                 go;
  mod503_pkg::operand_u operand;

  // --------------------
  // Word collection
  // --------------------

  reduce_ctrl u_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .word_valid   (word_valid),
    .last_word    (last_word),
    .result_valid (result_valid),
    .shift_en     (shift_en),
    .go           (go),
    .busy         (busy)
  );

  word_counter #(
    .NUM_WORDS (NUM_WORDS)
  ) u_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .shift_en  (shift_en),
    .last_word (last_word)
  );

  operand_shifter #(
    .WORD_W (WORD_W)
  ) u_shifter (
    .clk      (clk),
    .arst_n   (arst_n),
    .shift_en (shift_en),
    .word     (word),
    .operand  (operand)
  );

  // --------------------
  // Reduction
  // --------------------

  mod_reduce_100 u_reduce (
    .clk          (clk),
    .arst_n       (arst_n),
    .go           (go),
    .operand      (operand),
    .result_valid (result_valid),
    .residue      (residue)
  );

endmodule

/* verification/mod503_model.svh */
`ifndef MOD503_MODEL_SVH
`define MOD503_MODEL_SVH

// Reference residue of a 100-bit value modulo 503.
// Plain long division, one operand bit per step, MSB first.
function automatic logic [8:0] mod503_ref(input logic [99:0] value);
  int         modulus;
  logic [9:0] rem;
  modulus = 503;
  rem     = '0;
  for (int i = 99; i >= 0; i--)
  begin
    rem = {rem[8:0], value[i]};  // Below 1006, fits 10 bits.
    if (rem >= 10'(modulus))
      rem = rem - 10'(modulus);
  end
  return rem[8:0];
endfunction

// Edge operand set: small boundaries, all ones, chunk boundary powers of two.
function automatic int edge_count();
  return 5 + 17 + 1;
endfunction

function automatic logic [99:0] edge_operand(input int idx);
  logic [99:0] one;
  one = 100'd1;
  case (idx)
    0:       return 100'd0;
    1:       return 100'd502;
    2:       return 100'd503;
    3:       return 100'd1006;
    4:       return {100{1'b1}};
    22:      return one << 99;
    default: return one << (6 * (idx - 5));  // Bits 0, 6, ... 96.
  endcase
endfunction

`endif

/* verification/tb_mod503.sv */
`timescale 1ns/1ps

module tb_mod503;

  parameter int WORD_W = 20;

  localparam int OPERAND_W    = 100;
  localparam int NUM_WORDS    = OPERAND_W / WORD_W;
  localparam int CLK_PERIOD   = 4;
  localparam int LATENCY      = 3;   // Edges from last word to result.
  localparam int RESULT_LIMIT = 20;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_GAPPED   = 50;
  localparam int NUM_DROP     = 20;
  localparam int MAX_GAP      = 3;
  localparam int TEST_CYCLES  = 10 + (NUM_RANDOM + 25) * (NUM_WORDS + 6) +
                                NUM_GAPPED * (NUM_WORDS * (MAX_GAP + 1) + 6) +
                                NUM_DROP * 2 * (NUM_WORDS + 7);
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD + 1000;

  logic              clk;
  logic              arst_n;
  logic              word_valid;
  logic [WORD_W-1:0] word;
  logic              busy;
  logic              result_valid;
  logic [8:0]        residue;

  integer seed;
  int     cycle_cnt;
  int     checks_done;
  int     error_count;

  `include "mod503_model.svh"

  mod503_top #(
    .WORD_W (WORD_W)
  ) uut (
    .clk          (clk),
    .arst_n       (arst_n),
    .word_valid   (word_valid),
    .word         (word),
    .busy         (busy),
    .result_valid (result_valid),
    .residue      (residue)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;  // Edges seen so far.

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic check_value(input string signal, input logic [127:0] actual,
                             input logic [127:0] expected);
    checks_done++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, signal, actual, expected);
    end
  endtask

  function automatic logic [99:0] random_operand();
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    return r[99:0];
  endfunction

  // Returns right after edge E, with the edge count before E.
  task automatic send_operand(input logic [99:0] op, input int max_gap, output int e_cnt);
    int gap;
    for (int w = 0; w < NUM_WORDS; w++)
    begin
      gap = (max_gap > 0) ? (($random(seed) & 32'h7fff_ffff) % (max_gap + 1)) : 0;
      repeat (gap)
      begin
        @(posedge clk);
        word_valid <= 1'b0;
      end
      @(posedge clk);
      word_valid <= 1'b1;
      word       <= op[OPERAND_W - 1 - w * WORD_W -: WORD_W];
    end
    @(posedge clk);
    e_cnt      = cycle_cnt;
    word_valid <= 1'b0;
  endtask

  task automatic await_result(input int e_cnt, input logic [99:0] op);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!result_valid && waited < RESULT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!result_valid)
    begin
      error_count++;
      $display("No result_valid pulse within %0d cycles of the last word", RESULT_LIMIT);
    end
    else
    begin
      check_value("result latency", cycle_cnt - e_cnt, LATENCY);
      check_value("residue", residue, mod503_ref(op));
      @(negedge clk);
      check_value("result_valid", result_valid, 1'b0);  // Single pulse.
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, error_count - errs_before);
  endtask

  // --------------------
  // Tests
  // --------------------

  initial
  begin
    int          errs_before;
    int          e_cnt;
    logic [99:0] op_a;
    logic [99:0] op_b;

    seed        = 32'hec47;
    cycle_cnt   = 0;
    checks_done = 0;
    error_count = 0;
    arst_n      = 1'b0;
    word_valid  = 1'b0;
    word        = '0;

    // Reset state.
    errs_before = error_count;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("busy", busy, 1'b0);
    check_value("result_valid", result_valid, 1'b0);
    check_value("residue", residue, 9'd0);
    report_test("reset_state", errs_before);

    errs_before = error_count;
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      op_a = random_operand();
      send_operand(op_a, 0, e_cnt);
      await_result(e_cnt, op_a);
    end
    report_test("random_operands", errs_before);

    errs_before = error_count;
    for (int n = 0; n < edge_count(); n++)
    begin
      op_a = edge_operand(n);
      send_operand(op_a, 0, e_cnt);
      await_result(e_cnt, op_a);
    end
    report_test("edge_operands", errs_before);

    errs_before = error_count;
    for (int n = 0; n < NUM_GAPPED; n++)
    begin
      op_a = random_operand();
      send_operand(op_a, MAX_GAP, e_cnt);
      await_result(e_cnt, op_a);
    end
    report_test("gapped_loading", errs_before);

    errs_before = error_count;
    for (int n = 0; n < NUM_DROP; n++)
    begin
      op_a = random_operand();
      op_b = random_operand();
      send_operand(op_a, 0, e_cnt);
      fork
        begin
          // Junk strobes land on the three busy edges.
          repeat (LATENCY)
          begin
            word_valid <= 1'b1;
            word       <= WORD_W'($random(seed));
            @(negedge clk);
            check_value("busy", busy, 1'b1);
            @(posedge clk);
          end
          word_valid <= 1'b0;
        end
        await_result(e_cnt, op_a);
      join
      send_operand(op_b, 0, e_cnt);
      @(negedge clk);
      check_value("residue", residue, mod503_ref(op_a));  // No reduction from junk.
      await_result(e_cnt, op_b);
    end
    report_test("drop_while_busy", errs_before);

    $display("Checks: %0d, errors: %0d", checks_done, error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+verification
hdl/mod503_pkg.sv
hdl/chunk_residue.sv
hdl/mod_reduce_100.sv
hdl/operand_shifter.sv
hdl/word_counter.sv
hdl/reduce_ctrl.sv
hdl/mod503_top.sv
verification/tb_mod503.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mod503 testbench with Verilator, then scan the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_mod503 \
  -o tb_mod503 > build.log 2>&1 \
  && ./obj_dir/tb_mod503 > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Result: PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
